/* include/vec_cfg.svh */
/*
  Build-time sizing of the vector unit.
  Only a 32-bit element width with LMUL 1 is supported, so VLMAX is VLEN / XLEN.
  VLMAX must divide evenly by the number of lanes.
*/
`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

// Scalar and element width in bits
`define VEC_XLEN 32
// Bits per vector register
`define VEC_VLEN 128
// Elements per register at SEW 32, LMUL 1
`define VEC_VLMAX (`VEC_VLEN / `VEC_XLEN)
// Lanes sharing the register file
`define VEC_NR_LANES 2
// Architectural vector registers
`define VEC_NR_VREGS 8
// Transaction id carried from request to response
`define VEC_TRANS_ID_W 3

`endif

/* source/vec_csr_unit.sv */
/*
  vl, vtype and vstart. Only e32 with m1 is legal; anything else sets vill and vl 0.
  vstart keeps only the low bits needed for VLMAX, higher write bits are dropped.
  vtype reads back with vill in bit XLEN-1, vsew in [5:3] and vlmul in [2:0].
*/
`timescale 1ns/1ps
`default_nettype none

`include "vec_cfg.svh"

module vec_csr_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  vec_pkg::csr_cmd_t   csr_cmd_i,
  input  logic                csr_cmd_valid_i,
  input  vec_pkg::vec_csr_e   csr_addr_i,
  output vec_pkg::csr_state_t csr_state_o,
  output vec_pkg::elem_t      csr_rdata_o
);
  import vec_pkg::*;

  localparam logic [2:0] SEW_E32 = 3'b010;
  localparam logic [2:0] LMUL_M1 = 3'b000;

  vlen_t  vl_q, vl_d;
  vlen_t  vstart_q, vstart_d;
  vtype_t vtype_q, vtype_d;
  logic   vtype_legal;

  // Requested vtype must be exactly e32, m1 and not already flagged
  assign vtype_legal = !csr_cmd_i.vtype_imm.vill && (csr_cmd_i.vtype_imm.vsew == SEW_E32) &&
                       (csr_cmd_i.vtype_imm.vlmul == LMUL_M1);

  always_comb begin : next_state
    vl_d     = vl_q;
    vstart_d = vstart_q;
    vtype_d  = vtype_q;
    if (csr_cmd_valid_i) begin
      case (csr_cmd_i.cmd)
        SETVL: begin
          if (vtype_legal) begin
            // vl = min(avl, VLMAX)
            vl_d    = (csr_cmd_i.avl > elem_t'(`VEC_VLMAX)) ? vlen_t'(`VEC_VLMAX)
                                                             : vlen_t'(csr_cmd_i.avl);
            vtype_d = csr_cmd_i.vtype_imm;
          end else begin
            vl_d    = '0;
            vtype_d = '{vill: 1'b1, default: '0};
          end
          vstart_d = '0;
        end
        WRITE_VSTART: vstart_d = vlen_t'(csr_cmd_i.wdata);
        CLEAR_VSTART: vstart_d = '0;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vl_q     <= '0;
      vstart_q <= '0;
      vtype_q  <= '{vill: 1'b1, default: '0};
    end else begin
      vl_q     <= vl_d;
      vstart_q <= vstart_d;
      vtype_q  <= vtype_d;
    end
  end

  assign csr_state_o = '{vl: vl_q, vtype: vtype_q, vstart: vstart_q};

  always_comb begin : read_mux
    csr_rdata_o = '0;
    if (csr_cmd_valid_i && (csr_cmd_i.cmd == SETVL)) begin
      // vsetvli answers with the vl it is about to write
      csr_rdata_o = elem_t'(vl_d);
    end else begin
      case (csr_addr_i)
        VL:     csr_rdata_o = elem_t'(vl_q);
        VTYPE: begin
          csr_rdata_o[`VEC_XLEN-1] = vtype_q.vill;
          csr_rdata_o[5:3]         = vtype_q.vsew;
          csr_rdata_o[2:0]         = vtype_q.vlmul;
        end
        VSTART: csr_rdata_o = elem_t'(vstart_q);
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/vec_dispatcher.sv */
/*
  Accepts one host request at a time and answers each with exactly one response.
  Reserved op codes, unknown CSR addresses and vector ops under vill return error.
  An erroneous request changes no state. The response follows acceptance by one cycle.
*/
`timescale 1ns/1ps
`default_nettype none

`include "vec_cfg.svh"

module vec_dispatcher (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Host request and response
  input  vec_pkg::acc_req_t   acc_req_i,
  input  logic                acc_req_valid_i,
  output logic                acc_req_ready_o,
  output vec_pkg::acc_resp_t  acc_resp_o,
  output logic                acc_resp_valid_o,
  input  logic                acc_resp_ready_i,
  // CSR unit
  output vec_pkg::csr_cmd_t   csr_cmd_o,
  output logic                csr_cmd_valid_o,
  input  vec_pkg::csr_state_t csr_state_i,
  input  vec_pkg::elem_t      csr_rdata_i,
  // Lanes
  output vec_pkg::lane_req_t  lane_req_o,
  output logic                lane_req_valid_o,
  input  vec_pkg::elem_t      lane_sum_i [`VEC_NR_LANES]
);
  import vec_pkg::*;

  disp_state_e state_q, state_d;
  logic        ready_q;
  acc_resp_t   resp_q, resp_d;
  logic        accept;
  logic        is_vec_op;
  logic        op_legal;
  elem_t       red_sum;

  assign accept = acc_req_valid_i && acc_req_ready_o;

  always_comb begin : decoder
    is_vec_op  = 1'b0;
    op_legal   = 1'b1;
    csr_cmd_o  = '{cmd: NONE, avl: acc_req_i.rs1, vtype_imm: acc_req_i.vtype_imm,
                   wdata: acc_req_i.rs1};
    lane_req_o = '{op: SPLAT, vd: acc_req_i.vd, vs1: acc_req_i.vs1, vs2: acc_req_i.vs2,
                   scalar: acc_req_i.rs1, vl: csr_state_i.vl, vstart: csr_state_i.vstart};
    case (acc_req_i.op)
      VSETVLI:     csr_cmd_o.cmd = SETVL;
      CSRR:        op_legal = acc_req_i.csr inside {VL, VTYPE, VSTART};
      CSRW_VSTART: csr_cmd_o.cmd = WRITE_VSTART;
      VMV_VX: begin
        is_vec_op     = 1'b1;
        lane_req_o.op = SPLAT;
      end
      VADD_VX: begin
        is_vec_op     = 1'b1;
        lane_req_o.op = ADD_VX;
      end
      VADD_VV: begin
        is_vec_op     = 1'b1;
        lane_req_o.op = ADD_VV;
      end
      VREDSUM: begin
        is_vec_op     = 1'b1;
        lane_req_o.op = RED;
      end
      // Reserved codes
      default: op_legal = 1'b0;
    endcase
    // Vector ops are illegal under vill and always retire vstart to 0
    if (is_vec_op) begin
      op_legal      = !csr_state_i.vtype.vill;
      csr_cmd_o.cmd = CLEAR_VSTART;
    end
  end

  // Side effects only for accepted, legal requests
  assign csr_cmd_valid_o  = accept && op_legal && (csr_cmd_o.cmd != NONE);
  assign lane_req_valid_o = accept && op_legal && is_vec_op;

  always_comb begin : response
    red_sum = '0;
    for (int l = 0; l < `VEC_NR_LANES; l++) begin
      red_sum = red_sum + lane_sum_i[l];
    end
    resp_d = '{trans_id: acc_req_i.trans_id, result: '0, error: !op_legal};
    if (op_legal) begin
      case (acc_req_i.op)
        VREDSUM:       resp_d.result = red_sum;
        // CSR unit forwards the new vl during SETVL
        VSETVLI, CSRR: resp_d.result = csr_rdata_i;
        default: ;
      endcase
    end
  end

  always_comb begin : fsm
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = RESP;
      RESP:    if (acc_resp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Registered so ready stays low until reset has been released
      ready_q <= (state_d == IDLE);
    end
  end

  // Response payload, held while the host back-pressures
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q <= resp_d;
    end
  end

  assign acc_req_ready_o  = ready_q;
  assign acc_resp_valid_o = (state_q == RESP);
  assign acc_resp_o       = resp_q;

endmodule

`default_nettype wire

/* source/vec_lane.sv */
/*
  One lane's slice of the vector register file.
  Element e sits in lane e % NR_LANES at slot e / NR_LANES.
  Registers clear to 0 on reset. The partial sum is combinational from the request.
*/
`timescale 1ns/1ps
`default_nettype none

`include "vec_cfg.svh"

module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  vec_pkg::lane_req_t lane_req_i,
  input  logic               lane_req_valid_i,
  output vec_pkg::elem_t     partial_sum_o
);
  import vec_pkg::*;

  localparam int unsigned NR_LANES = `VEC_NR_LANES;
  localparam int unsigned NR_SLOTS = `VEC_VLMAX / NR_LANES;

  // Register slice, one row per architectural register
  elem_t vrf_q [`VEC_NR_VREGS][NR_SLOTS];

  vlen_t slot_idx    [NR_SLOTS];
  logic  slot_active [NR_SLOTS];
  elem_t slot_result [NR_SLOTS];

  always_comb begin : slot_ops
    for (int s = 0; s < NR_SLOTS; s++) begin
      // Global element index held by this slot
      slot_idx[s]    = vlen_t'(s * NR_LANES + LANE_ID);
      // Body elements only, prestart and tail stay undisturbed
      slot_active[s] = (slot_idx[s] >= lane_req_i.vstart) && (slot_idx[s] < lane_req_i.vl);
      case (lane_req_i.op)
        SPLAT:   slot_result[s] = lane_req_i.scalar;
        ADD_VX:  slot_result[s] = vrf_q[lane_req_i.vs2][s] + lane_req_i.scalar;
        ADD_VV:  slot_result[s] = vrf_q[lane_req_i.vs2][s] + vrf_q[lane_req_i.vs1][s];
        default: slot_result[s] = vrf_q[lane_req_i.vd][s];
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < `VEC_NR_VREGS; r++) begin
        for (int s = 0; s < NR_SLOTS; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else if (lane_req_valid_i && (lane_req_i.op != RED)) begin
      for (int s = 0; s < NR_SLOTS; s++) begin
        if (slot_active[s]) begin
          vrf_q[lane_req_i.vd][s] <= slot_result[s];
        end
      end
    end
  end

  // Wrapping sum of the active vs2 elements in this lane
  always_comb begin : reduction
    partial_sum_o = '0;
    for (int s = 0; s < NR_SLOTS; s++) begin
      if (slot_active[s]) begin
        partial_sum_o = partial_sum_o + vrf_q[lane_req_i.vs2][s];
      end
    end
  end

endmodule

`default_nettype wire

/* source/vec_pkg.sv */
/*
  Shared types of the vector accelerator and its testbench.
  Op codes 7 to 15 are reserved and are answered with an error.
*/
`default_nettype none

`include "vec_cfg.svh"

package vec_pkg;

  // Element and scalar data
  typedef logic [`VEC_XLEN-1:0] elem_t;
  // Holds 0 .. VLMAX inclusive, used for vl and vstart
  typedef logic [$clog2(`VEC_VLMAX):0] vlen_t;
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_t;
  typedef logic [`VEC_TRANS_ID_W-1:0] trans_id_t;

  // Pre-decoded host operations
  typedef enum logic [3:0] {
    VSETVLI     = 4'd0,
    CSRR        = 4'd1,
    CSRW_VSTART = 4'd2,
    VMV_VX      = 4'd3,
    VADD_VX     = 4'd4,
    VADD_VV     = 4'd5,
    VREDSUM     = 4'd6
  } vec_op_e;

  typedef enum logic [1:0] {
    VL     = 2'd0,
    VTYPE  = 2'd1,
    VSTART = 2'd2
  } vec_csr_e;

  typedef struct packed {
    logic       vill;
    logic [2:0] vsew;
    logic [2:0] vlmul;
  } vtype_t;

  // Request from the host core
  typedef struct packed {
    trans_id_t trans_id;
    vec_op_e   op;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    vec_csr_e  csr;
    vtype_t    vtype_imm;
    elem_t     rs1;
  } acc_req_t;

  typedef struct packed {
    trans_id_t trans_id;
    elem_t     result;
    logic      error;
  } acc_resp_t;

  // Architectural CSR view presented by the CSR unit
  typedef struct packed {
    vlen_t  vl;
    vtype_t vtype;
    vlen_t  vstart;
  } csr_state_t;

  typedef enum logic [1:0] {
    NONE,
    SETVL,
    WRITE_VSTART,
    CLEAR_VSTART
  } csr_cmd_e;

  typedef struct packed {
    csr_cmd_e cmd;
    elem_t    avl;
    vtype_t   vtype_imm;
    elem_t    wdata;
  } csr_cmd_t;

  typedef enum logic [1:0] {
    SPLAT,
    ADD_VX,
    ADD_VV,
    RED
  } lane_op_e;

  // Broadcast to every lane
  typedef struct packed {
    lane_op_e op;
    vreg_t    vd;
    vreg_t    vs1;
    vreg_t    vs2;
    elem_t    scalar;
    vlen_t    vl;
    vlen_t    vstart;
  } lane_req_t;

  typedef enum logic {
    IDLE,
    RESP
  } disp_state_e;

endpackage

`default_nettype wire

/* source/vec_top.sv */
/*
  Vector accelerator top. One request in flight, one response per request.
  Lanes receive the same broadcast operation and each returns a partial sum.
*/
`timescale 1ns/1ps
`default_nettype none

`include "vec_cfg.svh"

module vec_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);
  import vec_pkg::*;

  csr_cmd_t   csr_cmd;
  logic       csr_cmd_valid;
  csr_state_t csr_state;
  elem_t      csr_rdata;
  lane_req_t  lane_req;
  logic       lane_req_valid;
  // Partial reductions, one per lane
  elem_t      lane_sum [`VEC_NR_LANES];

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .acc_req_i        (acc_req_i),
    .acc_req_valid_i  (acc_req_valid_i),
    .acc_req_ready_o  (acc_req_ready_o),
    .acc_resp_o       (acc_resp_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .csr_cmd_o        (csr_cmd),
    .csr_cmd_valid_o  (csr_cmd_valid),
    .csr_state_i      (csr_state),
    .csr_rdata_i      (csr_rdata),
    .lane_req_o       (lane_req),
    .lane_req_valid_o (lane_req_valid),
    .lane_sum_i       (lane_sum)
  );

  // CSR read address comes straight from the host request
  vec_csr_unit i_csr_unit (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .csr_cmd_i       (csr_cmd),
    .csr_cmd_valid_i (csr_cmd_valid),
    .csr_addr_i      (acc_req_i.csr),
    .csr_state_o     (csr_state),
    .csr_rdata_o     (csr_rdata)
  );

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (l)
    ) i_lane (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .lane_req_i       (lane_req),
      .lane_req_valid_i (lane_req_valid),
      .partial_sum_o    (lane_sum[l])
    );
  end

endmodule

`default_nettype wire

/* verification/vec_sva.sv */
/*
  Host port protocol checks, bound into every vec_dispatcher instance.
  Failures go through $error and are counted in fail_count for the testbench.
*/
`timescale 1ns/1ps
`default_nettype none

module vec_sva (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               acc_req_valid_i,
  input logic               acc_req_ready_o,
  input vec_pkg::acc_resp_t acc_resp_o,
  input logic               acc_resp_valid_o,
  input logic               acc_resp_ready_i
);

  int unsigned fail_count = 0;
  logic        accept;

  assign accept = acc_req_valid_i && acc_req_ready_o;

  // Response is registered at the acceptance edge
  a_resp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |=> acc_resp_valid_o)
    else begin
      $error("response valid did not rise one cycle after acceptance");
      fail_count++;
    end

  // No response without a request accepted one cycle earlier
  a_resp_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(acc_resp_valid_o) |-> $past(accept))
    else begin
      $error("response valid rose without an accepted request");
      fail_count++;
    end

  // Held payload under back-pressure
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (acc_resp_valid_o && !acc_resp_ready_i) |=> (acc_resp_valid_o && $stable(acc_resp_o)))
    else begin
      $error("response changed or dropped while back-pressured");
      fail_count++;
    end

  // One request in flight
  a_ready_xor_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(acc_req_ready_o && acc_resp_valid_o))
    else begin
      $error("request ready and response valid were high together");
      fail_count++;
    end

  a_no_resp_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !acc_resp_valid_o)
    else begin
      $error("response valid was high in the first cycle after reset");
      fail_count++;
    end

endmodule

`default_nettype wire

/* verification/vec_tb.sv */
/*
  Directed test of vec_top against a reference model of the CSRs and registers.
  Response back-pressure gaps come from an LCG with a fixed seed.
  Protocol timing is checked by vec_sva, bound to the dispatcher.
*/
`timescale 1ns/1ps
`default_nettype none

`include "vec_cfg.svh"

module vec_tb;
  import vec_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam vtype_t VT_OK  = '{vill: 1'b0, vsew: 3'b010, vlmul: 3'b000};
  // SEW 64 is not supported
  localparam vtype_t VT_BAD = '{vill: 1'b0, vsew: 3'b011, vlmul: 3'b000};

  logic      clk_i;
  logic      rst_n_i;
  acc_req_t  acc_req_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;

  int        errors = 0;
  int        cycles = 0;
  int        stall_cycles = 0;
  logic [31:0] lcg_state = 32'hb4bd_81d9;
  trans_id_t next_id = '0;
  elem_t     last_result;

  // Reference state
  elem_t     m_vrf [`VEC_NR_VREGS][`VEC_VLMAX];
  int        m_vl = 0;
  int        m_vstart = 0;
  vtype_t    m_vtype = '{vill: 1'b1, default: '0};

  vec_top i_dut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .acc_req_i        (acc_req_i),
    .acc_req_valid_i  (acc_req_valid_i),
    .acc_req_ready_o  (acc_req_ready_o),
    .acc_resp_o       (acc_resp_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

  bind vec_dispatcher vec_sva i_sva (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .acc_req_valid_i  (acc_req_valid_i),
    .acc_req_ready_o  (acc_req_ready_o),
    .acc_resp_o       (acc_resp_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the DUT stopped answering before the test sequence ended");
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("FAILED %s expected %0h actual %0h", name, exp, act);
      errors++;
    end
  endtask

  // Applies one request to the reference state and gives the expected response
  task automatic model_step(input acc_req_t req, output acc_resp_t exp);
    elem_t sum;
    logic  legal_vt;
    sum = '0;
    exp = '{trans_id: req.trans_id, result: '0, error: 1'b0};
    case (req.op)
      VSETVLI: begin
        legal_vt = !req.vtype_imm.vill && (req.vtype_imm.vsew == 3'b010) &&
                   (req.vtype_imm.vlmul == 3'b000);
        if (legal_vt) begin
          m_vl    = (req.rs1 > `VEC_VLMAX) ? `VEC_VLMAX : int'(req.rs1);
          m_vtype = req.vtype_imm;
        end else begin
          m_vl    = 0;
          m_vtype = '{vill: 1'b1, default: '0};
        end
        m_vstart   = 0;
        exp.result = elem_t'(m_vl);
      end
      CSRR: begin
        case (req.csr)
          VL:      exp.result = elem_t'(m_vl);
          VTYPE:   exp.result = {m_vtype.vill, 25'd0, m_vtype.vsew, m_vtype.vlmul};
          VSTART:  exp.result = elem_t'(m_vstart);
          default: exp.error = 1'b1;
        endcase
      end
      // vstart register keeps three bits
      CSRW_VSTART: m_vstart = int'(req.rs1 & 32'h7);
      VMV_VX, VADD_VX, VADD_VV, VREDSUM: begin
        if (m_vtype.vill) begin
          exp.error = 1'b1;
        end else begin
          // Body elements only
          for (int e = m_vstart; e < m_vl; e++) begin
            case (req.op)
              VMV_VX:  m_vrf[req.vd][e] = req.rs1;
              VADD_VX: m_vrf[req.vd][e] = m_vrf[req.vs2][e] + req.rs1;
              VADD_VV: m_vrf[req.vd][e] = m_vrf[req.vs2][e] + m_vrf[req.vs1][e];
              default: sum = sum + m_vrf[req.vs2][e];
            endcase
          end
          if (req.op == VREDSUM) exp.result = sum;
          m_vstart = 0;
        end
      end
      default: exp.error = 1'b1;
    endcase
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic send_req(input acc_req_t req, output acc_resp_t resp);
    logic stall;
    acc_req_i       = req;
    acc_req_valid_i = 1'b1;
    // Ready seen here means the transfer happens at the next edge
    while (!acc_req_ready_o) begin
      @(posedge clk_i);
      #2;
    end
    @(posedge clk_i);
    #2;
    acc_req_valid_i = 1'b0;
    while (!acc_resp_valid_o) begin
      @(posedge clk_i);
      #2;
    end
    resp = acc_resp_o;
    do begin
      stall            = (next_rand() >> 30) == 0;
      acc_resp_ready_i = !stall;
      @(posedge clk_i);
      #2;
      if (stall) begin
        stall_cycles++;
        check_eq("back-pressure response hold", 64'(resp), 64'(acc_resp_o));
        check_eq("back-pressure response valid", 1, acc_resp_valid_o);
        check_eq("back-pressure request ready", 0, acc_req_ready_o);
      end
    end while (stall);
    acc_resp_ready_i = 1'b0;
  endtask

  task automatic issue(input string name, input vec_op_e op, input vreg_t vd, input vreg_t vs1,
                       input vreg_t vs2, input vec_csr_e csr, input vtype_t vt,
                       input elem_t rs1);
    acc_req_t  req;
    acc_resp_t exp_resp;
    acc_resp_t resp;
    req = '{trans_id: next_id, op: op, vd: vd, vs1: vs1, vs2: vs2, csr: csr,
            vtype_imm: vt, rs1: rs1};
    next_id = next_id + 1'b1;
    model_step(req, exp_resp);
    send_req(req, resp);
    check_eq({name, " trans_id"}, exp_resp.trans_id, resp.trans_id);
    check_eq({name, " error"}, exp_resp.error, resp.error);
    check_eq({name, " result"}, exp_resp.result, resp.result);
    last_result = resp.result;
  endtask

  initial begin : stimulus
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      for (int e = 0; e < `VEC_VLMAX; e++) begin
        m_vrf[r][e] = '0;
      end
    end
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b0;
    rst_n_i          = 1'b0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    // vsetvli clamps avl to VLMAX
    issue("vsetvli avl 2", VSETVLI, 0, 0, 0, VL, VT_OK, 2);
    check_eq("vsetvli avl 2 vl", 2, last_result);
    issue("vsetvli avl 4", VSETVLI, 0, 0, 0, VL, VT_OK, 4);
    check_eq("vsetvli avl 4 vl", 4, last_result);
    issue("vsetvli avl 9", VSETVLI, 0, 0, 0, VL, VT_OK, 9);
    check_eq("vsetvli avl 9 vl", 4, last_result);
    issue("csrr vl", CSRR, 0, 0, 0, VL, VT_OK, 0);
    issue("vsetvli bad sew", VSETVLI, 0, 0, 0, VL, VT_BAD, 3);
    check_eq("vsetvli bad sew vl", 0, last_result);
    issue("csrr vtype", CSRR, 0, 0, 0, VTYPE, VT_OK, 0);
    check_eq("csrr vtype vill", 1, last_result[31]);

    // Arithmetic, wrap-around and reduction
    issue("setvl 4", VSETVLI, 0, 0, 0, VL, VT_OK, 4);
    issue("splat v1", VMV_VX, 1, 0, 0, VL, VT_OK, 32'd7);
    issue("vadd.vx v2", VADD_VX, 2, 0, 1, VL, VT_OK, next_rand());
    issue("vadd.vv v3", VADD_VV, 3, 1, 2, VL, VT_OK, 0);
    issue("splat v4", VMV_VX, 4, 0, 0, VL, VT_OK, 32'hffff_fff0);
    issue("vadd.vx v4 wrap", VADD_VX, 4, 0, 4, VL, VT_OK, 32'h0000_0020);
    issue("vredsum v3", VREDSUM, 0, 0, 3, VL, VT_OK, 0);
    issue("vredsum v4", VREDSUM, 0, 0, 4, VL, VT_OK, 0);
    issue("setvl 1", VSETVLI, 0, 0, 0, VL, VT_OK, 1);
    issue("vredsum v3 element 0", VREDSUM, 0, 0, 3, VL, VT_OK, 0);
    issue("setvl 2", VSETVLI, 0, 0, 0, VL, VT_OK, 2);
    issue("csrw vstart 1", CSRW_VSTART, 0, 0, 0, VL, VT_OK, 1);
    issue("vredsum v3 element 1", VREDSUM, 0, 0, 3, VL, VT_OK, 0);

    // Tail elements stay undisturbed
    issue("tail setvl 4", VSETVLI, 0, 0, 0, VL, VT_OK, 4);
    issue("tail splat 1", VMV_VX, 5, 0, 0, VL, VT_OK, 1);
    issue("tail setvl 2", VSETVLI, 0, 0, 0, VL, VT_OK, 2);
    issue("tail splat 5", VMV_VX, 5, 0, 0, VL, VT_OK, 5);
    issue("tail setvl 4 again", VSETVLI, 0, 0, 0, VL, VT_OK, 4);
    issue("tail vredsum", VREDSUM, 0, 0, 5, VL, VT_OK, 0);
    check_eq("tail vredsum sum", 12, last_result);

    // Prestart elements stay undisturbed and vstart retires to 0
    issue("vstart splat 3", VMV_VX, 6, 0, 0, VL, VT_OK, 3);
    issue("csrw vstart 2", CSRW_VSTART, 0, 0, 0, VL, VT_OK, 2);
    issue("csrr vstart 2", CSRR, 0, 0, 0, VSTART, VT_OK, 0);
    issue("vstart vadd.vx", VADD_VX, 6, 0, 6, VL, VT_OK, 100);
    issue("csrr vstart cleared", CSRR, 0, 0, 0, VSTART, VT_OK, 0);
    check_eq("csrr vstart cleared value", 0, last_result);
    issue("vstart vredsum", VREDSUM, 0, 0, 6, VL, VT_OK, 0);
    issue("vstart setvl 2", VSETVLI, 0, 0, 0, VL, VT_OK, 2);
    issue("vstart vredsum low", VREDSUM, 0, 0, 6, VL, VT_OK, 0);
    check_eq("vstart low elements", 6, last_result);

    // Errors leave the state unchanged
    issue("err setvl 4", VSETVLI, 0, 0, 0, VL, VT_OK, 4);
    issue("reserved op", vec_op_e'(4'd9), 6, 0, 6, VL, VT_OK, 55);
    issue("err setvl bad", VSETVLI, 0, 0, 0, VL, VT_BAD, 4);
    // vl is 0 under vill, so vstart is the state a rejected vector op could touch
    issue("err csrw vstart under vill", CSRW_VSTART, 0, 0, 0, VL, VT_OK, 1);
    issue("vadd.vx under vill", VADD_VX, 6, 0, 6, VL, VT_OK, 9);
    issue("splat under vill", VMV_VX, 6, 0, 0, VL, VT_OK, 9);
    issue("vredsum under vill", VREDSUM, 0, 0, 6, VL, VT_OK, 0);
    issue("err csrr vstart under vill", CSRR, 0, 0, 0, VSTART, VT_OK, 0);
    issue("err setvl 4 again", VSETVLI, 0, 0, 0, VL, VT_OK, 4);
    issue("err vredsum v6", VREDSUM, 0, 0, 6, VL, VT_OK, 0);

    assert (stall_cycles > 0) else begin
      $display("No response back-pressure cycle was generated during the run");
      errors++;
    end

    $display("Checks finished: %0d testbench errors, %0d assertion failures",
             errors, i_dut.i_dispatcher.i_sva.fail_count);
    if ((errors == 0) && (i_dut.i_dispatcher.i_sva.fail_count == 0)) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/vec_pkg.sv
source/vec_csr_unit.sv
source/vec_lane.sv
source/vec_dispatcher.sv
source/vec_top.sv
verification/vec_sva.sv
verification/vec_tb.sv
